// File: correlator_defs.svh
`ifndef CORRELATOR_DEFS_SVH
`define CORRELATOR_DEFS_SVH

// Array geometry
`define NUM_ANTENNAS 4
`define NUM_BASELINES 6

// Samples summed into one visibility
`define VIS_COUNT 12

// Signed width of each re/im component
`define ACC_BITS 16

// Serialized size of one visibility word
`define VIS_BYTES 4

`endif

// File: src/correlator_pkg.sv
`include "correlator_defs.svh"
`default_nettype none

package correlator_pkg;

  typedef logic [`NUM_ANTENNAS-1:0] ant_bits_t;  // 1 is +1, 0 is -1
  typedef logic signed [`ACC_BITS-1:0] acc_t;
  typedef logic [7:0] byte_t;

  typedef struct packed {
    acc_t re;
    acc_t im;
  } vis_parts_t;

  // Byte 0 is im[7:0], byte 3 is re[15:8]
  typedef union packed {
    vis_parts_t parts;
    byte_t [`VIS_BYTES-1:0] bytes;
  } vis_word_t;

  // Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
  function automatic int baseline_ant_a(input int bl);
    case (bl)
      0, 1, 2: return 0;
      3, 4:    return 1;
      default: return 2;
    endcase
  endfunction

  function automatic int baseline_ant_b(input int bl);
    case (bl)
      0:       return 1;
      1, 3:    return 2;
      default: return 3;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: src/sig_frontend.sv
`timescale 1ns/100ps
`include "correlator_defs.svh"
`default_nettype none

module sig_frontend (
  input  logic                     vis_clock,
  input  logic                     vis_reset,
  input  logic                     sig_valid_i,
  input  correlator_pkg::ant_bits_t sig_idata_i,
  input  correlator_pkg::ant_bits_t sig_qdata_i,
  output logic                     samp_valid_o,
  output logic                     samp_first_o,
  output logic                     samp_last_o,
  output correlator_pkg::ant_bits_t samp_idata_o,
  output correlator_pkg::ant_bits_t samp_qdata_o,
  output logic                     vis_start_o,
  output logic                     vis_frame_o
);

  localparam int CNT_BITS = $clog2(`VIS_COUNT);

  logic [CNT_BITS-1:0] samp_cnt;  // Position within current frame
  logic                cnt_at_last;

  assign cnt_at_last = (samp_cnt == CNT_BITS'(`VIS_COUNT - 1));

  // Frame position counter, only advances on valid input
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      samp_cnt <= '0;
    end else if (sig_valid_i) begin
      samp_cnt <= cnt_at_last ? '0 : samp_cnt + 1'b1;
    end
  end

  // Flags registered alongside the data
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      samp_valid_o <= 1'b0;
      samp_first_o <= 1'b0;
      samp_last_o  <= 1'b0;
    end else begin
      samp_valid_o <= sig_valid_i;
      samp_first_o <= sig_valid_i && (samp_cnt == '0);
      samp_last_o  <= sig_valid_i && cnt_at_last;
    end
  end

  always_ff @(posedge vis_clock) begin
    samp_idata_o <= sig_idata_i;
    samp_qdata_o <= sig_qdata_i;
  end

  // Status: start fires once, frame then stays up until reset
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      vis_start_o <= 1'b0;
      vis_frame_o <= 1'b0;
    end else begin
      if (!vis_frame_o && sig_valid_i) begin
        vis_start_o <= 1'b1;
        vis_frame_o <= 1'b1;
      end else begin
        vis_start_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/baseline_core.sv
`timescale 1ns/100ps
`include "correlator_defs.svh"
`default_nettype none

module baseline_core #(
  parameter int ANT_A = 0,
  parameter int ANT_B = 1
) (
  input  logic                      vis_clock,
  input  logic                      vis_reset,
  input  logic                      samp_valid_i,
  input  logic                      samp_first_i,
  input  logic                      samp_last_i,
  input  correlator_pkg::ant_bits_t samp_idata_i,
  input  correlator_pkg::ant_bits_t samp_qdata_i,
  input  logic                      hold_ready_i,
  output logic                      hold_valid_o,
  output correlator_pkg::vis_word_t hold_word_o,
  output logic                      ovf_pulse_o
);

  import correlator_pkg::*;

  // Product of two one-bit samples, each meaning +1 or -1
  function automatic logic signed [2:0] pm_prod(input logic x, input logic y);
    return (x ~^ y) ? 3'sd1 : -3'sd1;
  endfunction

  logic ia, qa, ib, qb;
  logic signed [2:0] re_term, im_term;  // Range -2..+2
  acc_t acc_re, acc_im;
  acc_t sum_re, sum_im;
  logic hold_free;

  assign ia = samp_idata_i[ANT_A];
  assign qa = samp_qdata_i[ANT_A];
  assign ib = samp_idata_i[ANT_B];
  assign qb = samp_qdata_i[ANT_B];

  // A times conj(B)
  assign re_term = pm_prod(ia, ib) + pm_prod(qa, qb);
  assign im_term = pm_prod(qa, ib) - pm_prod(ia, qb);

  // Running sum including this sample, restarted by samp_first
  assign sum_re = (samp_first_i ? acc_t'(0) : acc_re) + acc_t'(re_term);
  assign sum_im = (samp_first_i ? acc_t'(0) : acc_im) + acc_t'(im_term);

  always_ff @(posedge vis_clock) begin
    if (samp_valid_i) begin
      acc_re <= sum_re;
      acc_im <= sum_im;
    end
  end

  // Slot is free if empty or being read this cycle
  assign hold_free = !hold_valid_o || hold_ready_i;

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      hold_valid_o <= 1'b0;
      ovf_pulse_o  <= 1'b0;
    end else begin
      ovf_pulse_o <= 1'b0;
      if (samp_valid_i && samp_last_i) begin
        if (hold_free) begin
          hold_valid_o <= 1'b1;
        end else begin
          ovf_pulse_o <= 1'b1;  // Previous result not drained yet
        end
      end else if (hold_ready_i) begin
        hold_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (samp_valid_i && samp_last_i && hold_free) begin
      hold_word_o.parts.re <= sum_re;
      hold_word_o.parts.im <= sum_im;
    end
  end

endmodule

`default_nettype wire

// File: src/vis_serializer.sv
`timescale 1ns/100ps
`include "correlator_defs.svh"
`default_nettype none

module vis_serializer (
  input  logic                      vis_clock,
  input  logic                      vis_reset,
  input  logic [`NUM_BASELINES-1:0] hold_valid_i,
  input  correlator_pkg::vis_word_t hold_word_i [`NUM_BASELINES],
  input  logic [`NUM_BASELINES-1:0] ovf_pulse_i,
  output logic [`NUM_BASELINES-1:0] hold_ready_o,
  output correlator_pkg::byte_t     vis_tdata_o,
  output logic                      vis_tvalid_o,
  output logic                      vis_tlast_o,
  input  logic                      vis_tready_i,
  output logic                      overflow_o
);

  import correlator_pkg::*;

  localparam int BL_BITS   = $clog2(`NUM_BASELINES);
  localparam int BYTE_BITS = $clog2(`VIS_BYTES);

  logic [BL_BITS-1:0]   bl_ptr;    // Core being visited
  logic [BYTE_BITS-1:0] byte_idx;  // Next byte of word_q to send
  vis_word_t            word_q;
  logic                 load;
  logic                 last_byte;
  logic                 last_bl;
  logic                 xfer;

  // Buffer is free whenever no byte is pending
  assign load      = !vis_tvalid_o && hold_valid_i[bl_ptr];
  assign xfer      = vis_tvalid_o && vis_tready_i;
  assign last_byte = (byte_idx == BYTE_BITS'(`VIS_BYTES - 1));
  assign last_bl   = (bl_ptr == BL_BITS'(`NUM_BASELINES - 1));

  always_comb begin
    hold_ready_o         = '0;
    hold_ready_o[bl_ptr] = load;  // One-cycle read strobe
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      bl_ptr       <= '0;
      byte_idx     <= '0;
      vis_tvalid_o <= 1'b0;
    end else if (load) begin
      byte_idx     <= '0;
      vis_tvalid_o <= 1'b1;
    end else if (xfer) begin
      if (last_byte) begin
        vis_tvalid_o <= 1'b0;
        bl_ptr       <= last_bl ? '0 : bl_ptr + 1'b1;
      end else begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (load) begin
      word_q <= hold_word_i[bl_ptr];
    end
  end

  // Held by the registers while the sink stalls
  assign vis_tdata_o = word_q.bytes[byte_idx];
  assign vis_tlast_o = vis_tvalid_o && last_byte && last_bl;

  // Sticky, cleared only by reset
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      overflow_o <= 1'b0;
    end else if (|ovf_pulse_i) begin
      overflow_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/toy_correlator.sv
`timescale 1ns/100ps
`include "correlator_defs.svh"
`default_nettype none

module toy_correlator (
  input  logic                      vis_clock,
  input  logic                      vis_reset,
  input  logic                      sig_valid_i,
  input  correlator_pkg::ant_bits_t sig_idata_i,
  input  correlator_pkg::ant_bits_t sig_qdata_i,
  output logic                      vis_start_o,
  output logic                      vis_frame_o,
  output correlator_pkg::byte_t     vis_tdata_o,
  output logic                      vis_tvalid_o,
  output logic                      vis_tlast_o,
  input  logic                      vis_tready_i,
  output logic                      overflow_o
);

  import correlator_pkg::*;

  // Sample fan-out from the front end
  logic      samp_valid, samp_first, samp_last;
  ant_bits_t samp_idata, samp_qdata;

  // Per-core hold interface
  logic [`NUM_BASELINES-1:0] hold_valid;
  logic [`NUM_BASELINES-1:0] hold_ready;
  logic [`NUM_BASELINES-1:0] ovf_pulse;
  vis_word_t                 hold_word [`NUM_BASELINES];

  sig_frontend i_frontend (
    .vis_clock    (vis_clock),
    .vis_reset    (vis_reset),
    .sig_valid_i  (sig_valid_i),
    .sig_idata_i  (sig_idata_i),
    .sig_qdata_i  (sig_qdata_i),
    .samp_valid_o (samp_valid),
    .samp_first_o (samp_first),
    .samp_last_o  (samp_last),
    .samp_idata_o (samp_idata),
    .samp_qdata_o (samp_qdata),
    .vis_start_o  (vis_start_o),
    .vis_frame_o  (vis_frame_o)
  );

  // One core per antenna pair
  for (genvar g = 0; g < `NUM_BASELINES; g++) begin : g_core
    baseline_core #(
      .ANT_A (baseline_ant_a(g)),
      .ANT_B (baseline_ant_b(g))
    ) i_core (
      .vis_clock    (vis_clock),
      .vis_reset    (vis_reset),
      .samp_valid_i (samp_valid),
      .samp_first_i (samp_first),
      .samp_last_i  (samp_last),
      .samp_idata_i (samp_idata),
      .samp_qdata_i (samp_qdata),
      .hold_ready_i (hold_ready[g]),
      .hold_valid_o (hold_valid[g]),
      .hold_word_o  (hold_word[g]),
      .ovf_pulse_o  (ovf_pulse[g])
    );
  end

  vis_serializer i_serializer (
    .vis_clock    (vis_clock),
    .vis_reset    (vis_reset),
    .hold_valid_i (hold_valid),
    .hold_word_i  (hold_word),
    .ovf_pulse_i  (ovf_pulse),
    .hold_ready_o (hold_ready),
    .vis_tdata_o  (vis_tdata_o),
    .vis_tvalid_o (vis_tvalid_o),
    .vis_tlast_o  (vis_tlast_o),
    .vis_tready_i (vis_tready_i),
    .overflow_o   (overflow_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic vis_clock,
  output logic vis_reset
);

  initial begin
    vis_clock = 1'b0;
    forever #20 vis_clock = ~vis_clock;  // 40 ns period
  end

  // Reset held for the first 8 rising edges
  initial begin
    vis_reset = 1'b1;
    repeat (8) @(posedge vis_clock);
    vis_reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tests/toy_correlator_properties.sv
`timescale 1ns/100ps
`default_nettype none

module toy_correlator_properties (
  input logic                  vis_clock,
  input logic                  vis_reset,
  input logic                  vis_tvalid_o,
  input logic                  vis_tready_i,
  input correlator_pkg::byte_t vis_tdata_o,
  input logic                  vis_tlast_o,
  input logic                  overflow_o,
  input logic                  vis_start_o,
  input logic                  vis_frame_o
);

  // Stalled byte must not change
  a_stall_hold: assert property (@(posedge vis_clock) disable iff (vis_reset)
    vis_tvalid_o && !vis_tready_i |=>
      vis_tvalid_o && $stable(vis_tdata_o) && $stable(vis_tlast_o))
    else $error("Output byte changed while the sink was stalling");

  a_ovf_sticky: assert property (@(posedge vis_clock) disable iff (vis_reset)
    overflow_o |=> overflow_o)
    else $error("overflow_o fell without a reset");

  a_start_frame: assert property (@(posedge vis_clock) disable iff (vis_reset)
    vis_start_o |=> vis_frame_o)
    else $error("vis_frame_o not high after vis_start_o");

endmodule

bind toy_correlator toy_correlator_properties i_props (.*);

`default_nettype wire

// File: tests/toy_correlator_tb.sv
`timescale 1ns/100ps
`include "correlator_defs.svh"
`default_nettype none

module toy_correlator_tb;

  import correlator_pkg::*;

  localparam int NUM_SAMPLES  = 2 * `VIS_COUNT;
  localparam int NUM_WORDS    = 2 * `NUM_BASELINES;
  localparam int BYTE_TIMEOUT = 400;
  localparam int SIG_TIMEOUT  = 2000;

  logic        vis_clock, vis_reset;
  logic        sig_valid_i;
  ant_bits_t   sig_idata_i, sig_qdata_i;
  logic        vis_tready_i = 1'b0;
  logic        vis_start_o, vis_frame_o, overflow_o;
  byte_t       vis_tdata_o;
  logic        vis_tvalid_o, vis_tlast_o;

  logic [31:0] vec [0:NUM_SAMPLES+NUM_WORDS-1];  // Samples then expected words
  logic [31:0] lfsr_state = 32'h5eb9;
  logic        hold_low = 1'b0;  // Sink fully stalled
  logic        started = 1'b0;
  logic        stalled = 1'b0;
  logic        ovf_seen = 1'b0;
  byte_t       stall_data;
  logic        stall_last;
  int          start_count = 0;
  int          mismatch_errors = 0;
  int          timeout_errors = 0;
  int          other_errors = 0;

  tb_clock_gen i_clk (.vis_clock(vis_clock), .vis_reset(vis_reset));

  toy_correlator i_dut (
    .vis_clock    (vis_clock),
    .vis_reset    (vis_reset),
    .sig_valid_i  (sig_valid_i),
    .sig_idata_i  (sig_idata_i),
    .sig_qdata_i  (sig_qdata_i),
    .vis_start_o  (vis_start_o),
    .vis_frame_o  (vis_frame_o),
    .vis_tdata_o  (vis_tdata_o),
    .vis_tvalid_o (vis_tvalid_o),
    .vis_tlast_o  (vis_tlast_o),
    .vis_tready_i (vis_tready_i),
    .overflow_o   (overflow_o)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int pm(input logic x, input logic y);
    return (x == y) ? 1 : -1;
  endfunction

  // Reference sum of A times conj(B) over one frame of the vector file
  function automatic vis_word_t model_word(input int f, input int bl);
    vis_word_t w;
    logic [7:0] s;
    int a, b, re, im;
    a = baseline_ant_a(bl);
    b = baseline_ant_b(bl);
    re = 0;
    im = 0;
    for (int i = 0; i < `VIS_COUNT; i++) begin
      s = vec[f * `VIS_COUNT + i][7:0];  // I nibble high, Q nibble low
      re += pm(s[4+a], s[4+b]) + pm(s[a], s[b]);
      im += pm(s[a], s[4+b]) - pm(s[4+a], s[b]);
    end
    w.parts.re = acc_t'(re);
    w.parts.im = acc_t'(im);
    return w;
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic check_word(input string name, input vis_word_t got, input vis_word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_errors + timeout_errors + other_errors;
    $display("Errors: %0d mismatches, %0d timeouts, %0d other",
             mismatch_errors, timeout_errors, other_errors);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Back-pressure, one LFSR bit per cycle
  always @(posedge vis_clock) begin
    if (hold_low) begin
      vis_tready_i <= 1'b0;
    end else begin
      vis_tready_i <= lfsr_state[0];
      lfsr_state   <= lfsr_step(lfsr_state);
    end
  end

  // Stall stability, status and sticky overflow
  always @(negedge vis_clock) begin
    if (!vis_reset) begin
      if (stalled) begin
        check_flag("vis_tvalid_o", vis_tvalid_o, 1'b1);
        check_byte("vis_tdata_o", vis_tdata_o, stall_data);
        check_flag("vis_tlast_o", vis_tlast_o, stall_last);
      end
      if (started) check_flag("vis_frame_o", vis_frame_o, 1'b1);
      if (ovf_seen) check_flag("overflow_o", overflow_o, 1'b1);
      if (vis_start_o) start_count++;
      ovf_seen = ovf_seen || overflow_o;
    end
    stalled    = vis_tvalid_o && !vis_tready_i && !vis_reset;
    stall_data = vis_tdata_o;
    stall_last = vis_tlast_o;
  end

  // One sample every 8 cycles
  task automatic drive_frame(input int f);
    logic [7:0] s;
    for (int i = 0; i < `VIS_COUNT; i++) begin
      s = vec[f * `VIS_COUNT + i][7:0];
      @(posedge vis_clock);
      sig_valid_i <= 1'b1;
      sig_idata_i <= s[7:4];
      sig_qdata_i <= s[3:0];
      for (int c = 1; c < 8; c++) begin
        @(posedge vis_clock);
        sig_valid_i <= 1'b0;
        if (!started && c == 1) begin
          @(negedge vis_clock);
          check_flag("vis_start_o", vis_start_o, 1'b1);
        end else if (!started && c == 2) begin
          @(negedge vis_clock);
          check_flag("vis_start_o", vis_start_o, 1'b0);
          started = 1'b1;
        end
      end
    end
  endtask

  task automatic wait_transfer(input int f, input int bl);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge vis_clock);
    while (!(vis_tvalid_o && vis_tready_i)) begin
      wait_cnt++;
      if (wait_cnt > BYTE_TIMEOUT) begin
        timeout_errors++;
        $display("ERROR: no output byte within %0d cycles (frame %0d, baseline %0d)",
                 BYTE_TIMEOUT, f, bl);
        return;
      end
      @(negedge vis_clock);
    end
  endtask

  // Bytes arrive little-endian, baselines 0 to 5
  task automatic collect_frame(input int f);
    vis_word_t w;
    for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
      for (int k = 0; k < `VIS_BYTES; k++) begin
        wait_transfer(f, bl);
        w.bytes[k] = vis_tdata_o;
        check_flag("vis_tlast_o", vis_tlast_o,
                   (bl == `NUM_BASELINES - 1) && (k == `VIS_BYTES - 1));
      end
      check_word($sformatf("vis_tdata_o word bl%0d frame%0d", bl, f), w,
                 vec[NUM_SAMPLES + f * `NUM_BASELINES + bl]);
    end
  endtask

  task automatic wait_signal(input string what, input logic want_tlast);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge vis_clock);
    while (want_tlast ? !(vis_tvalid_o && vis_tready_i && vis_tlast_o) : vis_reset) begin
      wait_cnt++;
      if (wait_cnt > SIG_TIMEOUT) begin
        timeout_errors++;
        $display("ERROR: timed out waiting for %s", what);
        return;
      end
      @(negedge vis_clock);
    end
  endtask

  initial begin
    sig_valid_i = 1'b0;
    sig_idata_i = '0;
    sig_qdata_i = '0;
    $readmemh("tests/correlator_vectors.hex", vec);
    if ($isunknown(vec[NUM_SAMPLES + NUM_WORDS - 1])) begin
      $display("ERROR: vector file did not load completely");
      other_errors++;
    end
    // The file's expected words must follow the conjugate-product rule
    for (int f = 0; f < 2; f++) begin
      for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
        if (model_word(f, bl) !== vec[NUM_SAMPLES + f * `NUM_BASELINES + bl]) begin
          $display("ERROR: expected word for baseline %0d frame %0d disagrees with A*conj(B)",
                   bl, f);
          other_errors++;
        end
      end
    end

    wait_signal("reset release", 1'b0);
    check_flag("vis_tvalid_o", vis_tvalid_o, 1'b0);
    check_flag("vis_tlast_o", vis_tlast_o, 1'b0);
    check_flag("vis_start_o", vis_start_o, 1'b0);
    check_flag("vis_frame_o", vis_frame_o, 1'b0);
    check_flag("overflow_o", overflow_o, 1'b0);

    // Two frames under random back-pressure
    fork
      begin
        drive_frame(0);
        drive_frame(1);
      end
      begin
        collect_frame(0);
        collect_frame(1);
      end
    join
    @(negedge vis_clock);
    check_flag("overflow_o", overflow_o, 1'b0);
    if (start_count != 1) begin
      $display("MISMATCH vis_start_o pulse count: got 0x%0h expected 0x1", start_count);
      mismatch_errors++;
    end

    // Sink stalled for three frames forces an overflow
    hold_low = 1'b1;
    drive_frame(0);
    drive_frame(1);
    drive_frame(0);
    @(negedge vis_clock);
    check_flag("overflow_o", overflow_o, 1'b1);
    hold_low = 1'b0;
    wait_signal("last byte after stall release", 1'b1);
    repeat (20) @(negedge vis_clock);
    check_flag("overflow_o", overflow_o, 1'b1);
    finish_run();
  end

endmodule

`default_nettype wire

// File: tests/correlator_vectors.hex
// Lines 0-23: one sample each, I nibble (antenna 3..0) then Q nibble
// Lines 24-35: expected {re, im} word per baseline 0..5, frame 0 then frame 1
F0
53
96
F0
53
F0
96
53
F0
96
53
F0
53
53
F0
96
53
53
96
53
F0
53
96
53
0004FFF8
00040008
00080000
00080000
0004FFF8
00040008
FFFEFFF2
FFFE000E
FFFC0000
FFFC0000
FFFEFFF2
FFFE000E

// File: toy_correlator.f
+incdir+.
src/correlator_pkg.sv
src/sig_frontend.sv
src/baseline_core.sv
src/vis_serializer.sv
src/toy_correlator.sv
tests/tb_clock_gen.sv
tests/toy_correlator_properties.sv
tests/toy_correlator_tb.sv

// File: Makefile
TOP = toy_correlator_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f toy_correlator.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
